// ==== logic/fmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  fpu_pkg::float32_t rs1,
  input  fpu_pkg::float32_t rs2,
  output logic              out_valid,
  output fpu_pkg::float32_t rd
);

  // stage 1, unpacked operands
  fpu_pkg::operand_t cls_a;
  fpu_pkg::operand_t cls_b;
  fpu_pkg::operand_t s1_a;
  fpu_pkg::operand_t s1_b;
  logic              s1_valid;

  // stage 2, raw product and special decision
  logic              special;
  fpu_pkg::float32_t special_val;
  fpu_pkg::prod_t    s2_next;
  fpu_pkg::prod_t    s2;
  logic              s2_valid;

  // stage 3, normalized result
  fpu_pkg::float32_t norm_res;

  fmul_classify classify_a_i (
    .in (rs1),
    .op (cls_a)
  );

  fmul_classify classify_b_i (
    .in (rs2),
    .op (cls_b)
  );

  // valid pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_a <= cls_a;
      s1_b <= cls_b;
    end
  end

  fmul_special special_i (
    .a           (s1_a),
    .b           (s1_b),
    .special     (special),
    .special_val (special_val)
  );

  // 24x24 significand multiply, exponent sum with bias removed once
  always_comb begin
    s2_next.sign        = s1_a.sign ^ s1_b.sign;
    s2_next.exp_sum     = 10'({1'b0, s1_a.exp_eff} + {1'b0, s1_b.exp_eff})
                          - 10'(fpu_pkg::exp_bias);
    s2_next.prod        = s1_a.sig * s1_b.sig;
    s2_next.special     = special;
    s2_next.special_val = special_val;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2 <= s2_next;
    end
  end

  fmul_normalize normalize_i (
    .sign    (s2.sign),
    .exp_sum (s2.exp_sum),
    .prod    (s2.prod),
    .res     (norm_res)
  );

  // rd holds between results
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      rd <= s2.special ? s2.special_val : norm_res;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fmul_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_classify (
  input  fpu_pkg::float32_t in,
  output fpu_pkg::operand_t op
);

  logic exp_zero;
  logic exp_ones;
  logic frac_zero;

  logic [8:0]                 exp_eff;
  logic [fpu_pkg::sig_w-1:0]  sig;
  fpu_pkg::op_class_t         cls;

  // exponent field extremes
  assign exp_zero  = (in.exp == 8'd0);
  assign exp_ones  = (in.exp == 8'(fpu_pkg::exp_all_ones));
  assign frac_zero = (in.frac == '0);

  // class flags
  always_comb begin
    cls.is_zero = exp_zero && frac_zero;
    cls.is_inf  = exp_ones && frac_zero;
    cls.is_nan  = exp_ones && !frac_zero;
  end

  // denormals use exponent 1 with no hidden bit
  always_comb begin
    if (exp_zero) begin
      exp_eff = 9'd1;
      sig     = {1'b0, in.frac};
    end else begin
      exp_eff = {1'b0, in.exp};
      sig     = {1'b1, in.frac};
    end
  end

  always_comb begin
    op.sign    = in.sign;
    op.cls     = cls;
    op.exp_eff = exp_eff;
    op.sig     = sig;
    op.raw     = in;
  end

endmodule

`default_nettype wire

// ==== logic/fmul_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_normalize (
  input  logic                          sign,
  input  logic signed [9:0]             exp_sum,
  input  logic [2*fpu_pkg::sig_w-1:0]   prod,
  output fpu_pkg::float32_t             res
);

  // leading one position of the product
  logic [5:0]          lead;
  logic                nonzero;

  // biased exponent after normalizing
  logic signed [10:0]  exp_norm;
  logic                denorm;
  logic                overflow;

  // signed shift, positive is a left shift
  logic signed [10:0]  lshift;
  logic signed [10:0]  rshift;
  logic [47:0]         aligned;

  // priority encoder, highest set bit wins
  always_comb begin
    lead    = 6'd0;
    nonzero = 1'b0;
    for (int i = 0; i < 2 * fpu_pkg::sig_w; i++) begin
      if (prod[i]) begin
        lead    = 6'(i);
        nonzero = 1'b1;
      end
    end
  end

  // exp_sum is the exponent for a leading one at bit 46
  assign exp_norm = exp_sum + $signed({5'b0, lead}) - 11'sd46;

  assign denorm   = (exp_norm < 11'sd1);
  assign overflow = (exp_norm >= 11'(fpu_pkg::exp_all_ones));

  // normal: leading one to bit 46
  // denormal: align so bit 46 carries weight 2^-126
  always_comb begin
    if (denorm) begin
      lshift = exp_sum - 11'sd1;
    end else begin
      lshift = 11'sd46 - $signed({5'b0, lead});
    end
    rshift = -lshift;
  end

  always_comb begin
    if (lshift >= 11'sd0) begin
      aligned = prod << lshift[5:0];
    end else if (rshift > 11'sd47) begin
      // everything shifted out, flush to zero
      aligned = '0;
    end else begin
      // low bits dropped, i.e. truncation
      aligned = prod >> rshift[5:0];
    end
  end

  // result assembly
  always_comb begin
    res.sign = sign;
    if (overflow) begin
      res.exp  = 8'(fpu_pkg::exp_all_ones);
      res.frac = '0;
    end else if (!nonzero) begin
      res.exp  = 8'd0;
      res.frac = '0;
    end else if (denorm) begin
      res.exp  = 8'd0;
      res.frac = aligned[45:23];
    end else begin
      res.exp  = exp_norm[7:0];
      res.frac = aligned[45:23];
    end
  end

endmodule

`default_nettype wire

// ==== logic/fmul_special.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmul_special (
  input  fpu_pkg::operand_t a,
  input  fpu_pkg::operand_t b,
  output logic              special,
  output fpu_pkg::float32_t special_val
);

  logic sign_xor;
  logic inf_times_zero;
  logic any_inf;
  logic any_zero;

  assign sign_xor = a.sign ^ b.sign;

  // invalid operation, either order
  assign inf_times_zero = (a.cls.is_inf && b.cls.is_zero) ||
                          (a.cls.is_zero && b.cls.is_inf);

  assign any_inf  = a.cls.is_inf || b.cls.is_inf;
  assign any_zero = a.cls.is_zero || b.cls.is_zero;

  // priority: rs1 NaN, rs2 NaN, inf*0, inf, zero
  always_comb begin
    special     = 1'b1;
    special_val = '0;
    if (a.cls.is_nan) begin
      // quiet bit forced, payload and sign kept
      special_val.sign = a.sign;
      special_val.exp  = 8'(fpu_pkg::exp_all_ones);
      special_val.frac = {1'b1, a.raw.frac[fpu_pkg::frac_w-2:0]};
    end else if (b.cls.is_nan) begin
      special_val.sign = b.sign;
      special_val.exp  = 8'(fpu_pkg::exp_all_ones);
      special_val.frac = {1'b1, b.raw.frac[fpu_pkg::frac_w-2:0]};
    end else if (inf_times_zero) begin
      special_val = fpu_pkg::qnan_canon;
    end else if (any_inf) begin
      special_val.sign = sign_xor;
      special_val.exp  = 8'(fpu_pkg::exp_all_ones);
      special_val.frac = '0;
    end else if (any_zero) begin
      special_val.sign = sign_xor;
      special_val.exp  = 8'd0;
      special_val.frac = '0;
    end else begin
      // both finite and nonzero, take the normal path
      special     = 1'b0;
      special_val = '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fpu_pkg.sv ====
package fpu_pkg;

  // single precision format widths
  localparam int frac_w = 23;
  localparam int sig_w  = 24;

  // exponent encodings
  localparam int exp_bias     = 127;
  localparam int exp_all_ones = 255;

  // one IEEE-754 single precision word
  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [frac_w-1:0] frac;
  } float32_t;

  // canonical quiet NaN, positive sign
  localparam float32_t qnan_canon = 32'h7fc0_0000;

  // operand class flags
  // finite nonzero values have all three low
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;
  } op_class_t;

  // one unpacked operand
  typedef struct packed {
    logic             sign;
    op_class_t        cls;
    // biased exponent, forced to 1 for denormals
    logic [8:0]       exp_eff;
    // significand including the hidden bit
    logic [sig_w-1:0] sig;
    // raw word, needed for NaN pass-through
    float32_t         raw;
  } operand_t;

  // stage 2 register contents
  typedef struct packed {
    logic               sign;
    // biased result exponent when the product's leading one sits at bit 46
    logic signed [9:0]  exp_sum;
    logic [2*sig_w-1:0] prod;
    // special result overrides the normalized product
    logic               special;
    float32_t           special_val;
  } prod_t;

endpackage

// ==== verif/fmul_ref.svh ====
`ifndef FMUL_REF_SVH
`define FMUL_REF_SVH

// expected rd for rs1 * rs2, round toward zero
function automatic logic [31:0] expected_product(input logic [31:0] a, input logic [31:0] b);
  logic         sa;
  logic         sb;
  logic         sr;
  logic [7:0]   ea;
  logic [7:0]   eb;
  logic [22:0]  fa;
  logic [22:0]  fb;
  logic [47:0]  ma;
  logic [47:0]  mb;
  logic [511:0] q;
  int           ea_eff;
  int           eb_eff;
  int           sh;
  int           msb;
  int           e;
  int           i;

  sa = a[31];
  sb = b[31];
  ea = a[30:23];
  eb = b[30:23];
  fa = a[22:0];
  fb = b[22:0];
  sr = sa ^ sb;

  // NaN operands, rs1 first, quiet bit set
  if (ea == 8'hff && fa != 23'd0)
    return {sa, 8'hff, 1'b1, fa[21:0]};
  if (eb == 8'hff && fb != 23'd0)
    return {sb, 8'hff, 1'b1, fb[21:0]};
  if ((ea == 8'hff && b[30:0] == 31'd0) || (eb == 8'hff && a[30:0] == 31'd0))
    return 32'h7fc0_0000;
  if (ea == 8'hff || eb == 8'hff)
    return {sr, 8'hff, 23'd0};
  if (a[30:0] == 31'd0 || b[30:0] == 31'd0)
    return {sr, 31'd0};

  // operand value is m * 2^(e - 150)
  ma = (ea == 8'd0) ? {25'd0, fa} : {24'd0, 1'b1, fa};
  mb = (eb == 8'd0) ? {25'd0, fb} : {24'd0, 1'b1, fb};
  ea_eff = (ea == 8'd0) ? 1 : int'(ea);
  eb_eff = (eb == 8'd0) ? 1 : int'(eb);

  // q is the exact product scaled by 2^149, floored
  q = 512'(ma) * 512'(mb);
  sh = ea_eff + eb_eff - 151;
  if (sh >= 0)
    q = q << sh;
  else
    q = q >> (-sh);

  if (q == '0)
    return {sr, 31'd0};

  msb = 0;
  for (i = 0; i < 512; i++) begin
    if (q[i])
      msb = i;
  end

  // below 2^-126 the scaled value is the denormal fraction itself
  if (msb < 23)
    return {sr, 8'd0, q[22:0]};

  e = msb - 22;
  if (e >= 255)
    return {sr, 8'hff, 23'd0};

  q = q >> (msb - 23);
  return {sr, 8'(e), q[22:0]};
endfunction

`endif

// ==== verif/fmul_tb.sv ====
`timescale 1ns/1ps

module fmul_tb;

  `include "fmul_ref.svh"

  localparam int n_directed = 29;
  localparam int n_random   = 2000;
  localparam int n_denormal = 200;
  localparam int n_gapped   = 100;
  localparam int n_ops      = n_directed + n_random + n_denormal + n_gapped;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  fpu_pkg::float32_t rs1;
  fpu_pkg::float32_t rs2;
  logic              out_valid;
  fpu_pkg::float32_t rd;

  // pending results in issue order
  logic [31:0] want_q[$];
  string       name_q[$];
  int          stamp_q[$];

  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  logic [31:0] want;
  string       name;
  int          stamp;
  logic [31:0] op_a;
  logic [31:0] op_b;
  int          k;

  tb_clock clock_i (
    .clk (clk)
  );

  fmul dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .rs1       (rs1),
    .rs2       (rs2),
    .out_valid (out_valid),
    .rd        (rd)
  );

  function automatic logic [31:0] random_normal(input int lo, input int hi);
    logic        s;
    logic [7:0]  e;
    logic [22:0] f;
    s = 1'($urandom);
    e = 8'(lo + ($urandom % (hi - lo + 1)));
    f = 23'($urandom);
    return {s, e, f};
  endfunction

  function automatic logic [31:0] random_denormal();
    logic        s;
    logic [22:0] f;
    s = 1'($urandom);
    f = 23'($urandom);
    // keep it nonzero
    if (f == 23'd0)
      f = 23'd1;
    return {s, 8'd0, f};
  endfunction

  task automatic issue_op(input string label, input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    in_valid <= 1'b1;
    rs1      <= a;
    rs2      <= b;
    want_q.push_back(expected_product(a, b));
    name_q.push_back(label);
    // in_valid is first seen high at the next falling edge
    stamp_q.push_back(cycle + 1);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // compare at the falling edge where outputs have settled
  always @(negedge clk) begin
    cycle = cycle + 1;
    // out_valid is known once the reset has taken hold
    if (cycle >= 2) begin
      assert (out_valid === 1'b0 || out_valid === 1'b1) else begin
        errors++;
        $display("ERROR: out_valid is unknown at cycle %0d", cycle);
      end
    end
    if (out_valid === 1'b1) begin
      assert (want_q.size() != 0) else begin
        errors++;
        $display("ERROR: out_valid high at cycle %0d with no operation in flight", cycle);
      end
      if (want_q.size() != 0) begin
        want  = want_q.pop_front();
        name  = name_q.pop_front();
        stamp = stamp_q.pop_front();
        checks++;
        assert (rd === want) else begin
          errors++;
          $display("FAILED %s: expected %08h, actual %08h", name, want, rd);
        end
        assert (cycle - stamp == 3) else begin
          errors++;
          $display("ERROR: %s came out %0d cycles after issue instead of 3", name,
                   cycle - stamp);
        end
      end
    end
  end

  // watchdog
  initial begin
    #((n_ops + 3 + 16) * 2 * 100);
    $display("ERROR: watchdog expired with %0d results still pending", want_q.size());
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    in_valid = 1'b0;
    rs1      = '0;
    rs2      = '0;
    rst_n    = 1'b0;
    void'($urandom(40023));

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // out_valid must stay low over a few quiet cycles
    idle_cycles(4);

    // directed normals
    issue_op("2 x 3", 32'h4000_0000, 32'h4040_0000);
    issue_op("1.5 x 1.5", 32'h3fc0_0000, 32'h3fc0_0000);
    issue_op("-2.5 x 4", 32'hc020_0000, 32'h4080_0000);
    issue_op("-1 x -1", 32'hbf80_0000, 32'hbf80_0000);
    issue_op("third x 3", 32'h3eaa_aaab, 32'h4040_0000);

    // NaN, infinity and zero
    issue_op("qnan rs1", 32'h7fc1_2345, 32'h3f80_0000);
    issue_op("snan rs1 x inf", 32'hff81_2345, 32'h7f80_0000);
    issue_op("snan rs2", 32'h3f80_0000, 32'h7f80_0001);
    issue_op("nan both", 32'h7fa0_0000, 32'hffc0_0007);
    issue_op("inf x 0", 32'h7f80_0000, 32'h0000_0000);
    issue_op("-0 x -inf", 32'h8000_0000, 32'hff80_0000);
    issue_op("inf x -2", 32'h7f80_0000, 32'hc000_0000);
    issue_op("denorm x -inf", 32'h0000_0001, 32'hff80_0000);
    issue_op("-0 x 5", 32'h8000_0000, 32'h40a0_0000);
    issue_op("-3 x 0", 32'hc040_0000, 32'h0000_0000);
    issue_op("-0 x -0", 32'h8000_0000, 32'h8000_0000);

    // denormal inputs and results
    issue_op("min denorm x 2", 32'h0000_0001, 32'h4000_0000);
    issue_op("denorm x 4", 32'h0040_0000, 32'h4080_0000);
    issue_op("denorm x 0.5", 32'h0000_0003, 32'h3f00_0000);
    issue_op("min normal x 0.5", 32'h0080_0000, 32'h3f00_0000);
    issue_op("denorm x denorm", 32'h0000_0001, 32'h0000_0001);
    issue_op("into denorm", 32'h1f80_0000, 32'ha000_0000);
    issue_op("flush to -0", 32'h0d80_0000, 32'h8d80_0000);
    issue_op("denorm x big", 32'h0000_0001, 32'h7f00_0000);
    issue_op("max denorm x max", 32'h007f_ffff, 32'h7f7f_ffff);

    // exponent overflow
    issue_op("max x 2", 32'h7f7f_ffff, 32'h4000_0000);
    issue_op("-2^100 x 2^100", 32'hf180_0000, 32'h7180_0000);
    issue_op("max x max", 32'h7f7f_ffff, 32'h7f7f_ffff);
    issue_op("just below max", 32'h7f00_0000, 32'h3fff_ffff);

    // back to back random normals
    for (k = 0; k < n_random; k++) begin
      op_a = random_normal(64, 190);
      op_b = random_normal(64, 190);
      issue_op($sformatf("random %0d", k), op_a, op_b);
    end

    // denormal against a normal in both orders
    for (k = 0; k < n_denormal; k++) begin
      op_a = random_denormal();
      op_b = random_normal(1, 254);
      if (k % 2 == 0)
        issue_op($sformatf("denormal %0d", k), op_a, op_b);
      else
        issue_op($sformatf("denormal %0d", k), op_b, op_a);
    end

    // random gaps between strobes
    for (k = 0; k < n_gapped; k++) begin
      idle_cycles($urandom % 4);
      op_a = random_normal(1, 254);
      op_b = random_normal(1, 254);
      issue_op($sformatf("gapped %0d", k), op_a, op_b);
    end

    idle_cycles(1);
    for (k = 0; k < 8 && want_q.size() != 0; k++)
      @(negedge clk);
    // stray out_valid pulses would show up here
    repeat (4) @(negedge clk);
    @(posedge clk);

    assert (want_q.size() == 0) else begin
      errors++;
      $display("ERROR: %0d results never came out of the DUT", want_q.size());
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 100 ns period, first rising edge at 50 ns
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+verif
logic/fpu_pkg.sv
logic/fmul_classify.sv
logic/fmul_special.sv
logic/fmul_normalize.sv
logic/fmul.sv
verif/tb_clock.sv
verif/fmul_tb.sv
